/* src.f */
+incdir+include
source/vng_pkg.sv
source/vng_control.sv
source/vng_window.sv
source/vng_grad.sv
source/vng_sum.sv
source/vng_out.sv
source/vng_top.sv
verification/vng_sva.sv
verification/vng_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module vng_tb -o vng_sim
	@out="$$(./obj_dir/vng_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* verification/vng_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vng_consts.svh"

module vng_tb;

localparam int CLK_PERIOD   = 8;
localparam int RESET_CYCLES = 5;
localparam int FLAT_WINS    = 3;
localparam int RAND_WINS    = 20;
localparam int EDGE_WINS    = 2;
localparam int MASK_WINS    = 2;
localparam int EN_WINS      = 15;
localparam int TOTAL_WINS   = FLAT_WINS + RAND_WINS + EDGE_WINS + MASK_WINS + EN_WINS + 2;
// Stalls on clk_en can stretch a push to several cycles
localparam int WATCH_NS     = (TOTAL_WINS * `VNG_WIN * 4 + 200) * CLK_PERIOD;

logic               clk;
logic               clk_en;
logic               reset;
logic               px_push;
vng_pkg::pixel_t    px_in;
logic               px_masked;
vng_pkg::pixel_t    out_red;
vng_pkg::pixel_t    out_green;
vng_pkg::pixel_t    out_blue;
logic               out_valid;

integer             seed = 79;
logic               en_random;
logic               en_next;
vng_pkg::pixel_t    next_win [`VNG_WIN];
vng_pkg::pixel_t    win [`VNG_WIN];     // Model copy of the window being pushed
logic               win_mask;
int                 win_cnt;
logic   [3*`VNG_DATA-1:0] exp_q [$];    // {red, green, blue}

vng_top dut (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .reset      ( reset ),
    .px_push    ( px_push ),
    .px_in      ( px_in ),
    .px_masked  ( px_masked ),
    .out_red    ( out_red ),
    .out_green  ( out_green ),
    .out_blue   ( out_blue ),
    .out_valid  ( out_valid )
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// Drawn at negedge so it never shares a time step with pixel draws
initial begin
    forever begin
        @(negedge clk);
        en_next = en_random ? (($random(seed) % 4) != 0) : 1'b1;
        @(posedge clk);
        #1;
        clk_en = en_next;
    end
end

initial begin
    #(WATCH_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCH_NS);
    $display("Result: FAILED");
    $fatal(1);
end

function automatic int abs_int(input int a);
    return (a < 0) ? -a : a;
endfunction

// Directions in order h, v, ne, se
function automatic logic [3*`VNG_DATA-1:0] model_rgb();
    int grad [4];
    int pair [4];
    int lo;
    int hi;
    int limit;
    int g_sum;
    int b_sum;
    int g_cnt;
    int b_cnt;
    int green;
    int blue;
    grad[0] = abs_int(int'(win[3]) - int'(win[5]));
    grad[1] = abs_int(int'(win[1]) - int'(win[7]));
    grad[2] = abs_int(int'(win[2]) - int'(win[6]));
    grad[3] = abs_int(int'(win[0]) - int'(win[8]));
    pair[0] = int'(win[3]) + int'(win[5]);
    pair[1] = int'(win[1]) + int'(win[7]);
    pair[2] = int'(win[2]) + int'(win[6]);
    pair[3] = int'(win[0]) + int'(win[8]);
    lo = grad[0];
    hi = grad[0];
    for (int d = 1; d < 4; d++) begin
        lo = (grad[d] < lo) ? grad[d] : lo;
        hi = (grad[d] > hi) ? grad[d] : hi;
    end
    limit = lo + (hi - lo) / 2;
    g_sum = 0;
    b_sum = 0;
    g_cnt = 0;
    b_cnt = 0;
    for (int d = 0; d < 4; d++) begin
        if (grad[d] <= limit && d < 2) begin
            g_sum += pair[d];
            g_cnt++;
        end else if (grad[d] <= limit) begin
            b_sum += pair[d];
            b_cnt++;
        end
    end
    green = (g_cnt == 0) ? (pair[0] + pair[1]) / 4 : g_sum / (2 * g_cnt);
    blue  = (b_cnt == 0) ? (pair[2] + pair[3]) / 4 : b_sum / (2 * b_cnt);
    if (win_mask) begin
        green = int'(win[4]);
        blue  = int'(win[4]);
    end
    return {win[4], vng_pkg::pixel_t'(green), vng_pkg::pixel_t'(blue)};
endfunction

task automatic report_value(input string name, input vng_pkg::pixel_t got,
                            input vng_pkg::pixel_t want);
    $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
    $display("Result: FAILED");
    $fatal(1);
endtask

task automatic report_error(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
endtask

always @(negedge clk) begin : check_output
    logic [3*`VNG_DATA-1:0] exp_rgb;
    if (!reset && clk_en && out_valid) begin
        assert (exp_q.size() != 0)
            else report_error("out_valid raised with no window expected");
        exp_rgb = exp_q.pop_front();
        assert (out_red == exp_rgb[2*`VNG_DATA +: `VNG_DATA])
            else report_value("out_red", out_red, exp_rgb[2*`VNG_DATA +: `VNG_DATA]);
        assert (out_green == exp_rgb[`VNG_DATA +: `VNG_DATA])
            else report_value("out_green", out_green, exp_rgb[`VNG_DATA +: `VNG_DATA]);
        assert (out_blue == exp_rgb[0 +: `VNG_DATA])
            else report_value("out_blue", out_blue, exp_rgb[0 +: `VNG_DATA]);
    end
end

task automatic push_px(input vng_pkg::pixel_t pix, input logic masked);
    px_push   = 1'b1;
    px_in     = pix;
    px_masked = masked;
    win[win_cnt] = pix;
    if (win_cnt == 4) begin
        win_mask = masked;
    end
    @(posedge clk);
    while (!clk_en) @(posedge clk);
    #1;
    px_push = 1'b0;
    win_cnt = win_cnt + 1;
    if (win_cnt == `VNG_WIN) begin
        exp_q.push_back(model_rgb());
        win_cnt = 0;
    end
endtask

// Stray mask bits off center must be ignored
task automatic push_window(input logic masked);
    for (int i = 0; i < `VNG_WIN; i++) begin
        push_px(next_win[i], (i == 4) ? masked : !masked);
    end
endtask

task automatic fill_random();
    for (int i = 0; i < `VNG_WIN; i++) begin
        next_win[i] = vng_pkg::pixel_t'($random(seed));
    end
endtask

// Opposite neighbors equal, so every gradient is zero
task automatic fill_flat();
    vng_pkg::pixel_t g_we;
    vng_pkg::pixel_t g_ns;
    vng_pkg::pixel_t b_ne;
    vng_pkg::pixel_t b_se;
    g_we = vng_pkg::pixel_t'($random(seed));
    g_ns = vng_pkg::pixel_t'($random(seed));
    b_ne = vng_pkg::pixel_t'($random(seed));
    b_se = vng_pkg::pixel_t'($random(seed));
    next_win = '{b_se, g_ns, b_ne, g_we, vng_pkg::pixel_t'($random(seed)),
                 g_we, b_ne, g_ns, b_se};
endtask

// Strong horizontal edge, only v survives the threshold
task automatic fill_edge();
    vng_pkg::pixel_t jitter;
    jitter = vng_pkg::pixel_t'($random(seed)) & 8'd3;
    next_win = '{8'd250, 8'd100 + jitter, 8'd20, 8'd10, 8'd128,
                 8'd240, 8'd230, 8'd104, 8'd5};
endtask

task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20 * `VNG_LAT) begin
        @(posedge clk);
        #1;
        waited++;
    end
    assert (exp_q.size() == 0)
        else report_error("Expected outputs never appeared");
endtask

initial begin
    clk_en    = 1'b1;
    reset     = 1'b1;
    px_push   = 1'b0;
    px_in     = '0;
    px_masked = 1'b0;
    en_random = 1'b0;
    win_cnt   = 0;
    win_mask  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (FLAT_WINS) begin
        fill_flat();
        push_window(1'b0);
    end
    repeat (RAND_WINS) begin
        fill_random();
        push_window(1'b0);
    end
    repeat (EDGE_WINS) begin
        fill_edge();
        push_window(1'b0);
    end
    repeat (MASK_WINS) begin
        fill_random();
        push_window(1'b1);
    end
    en_random = 1'b1;
    repeat (EN_WINS) begin
        fill_random();
        push_window(1'($random(seed)));
    end
    en_random = 1'b0;
    drain_results();

    // Window in flight plus two pixels, then reset kills both
    fill_random();
    push_window(1'b0);
    push_px(next_win[0], 1'b0);
    push_px(next_win[1], 1'b0);
    reset = 1'b1;
    exp_q.delete();
    win_cnt = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    fill_random();
    push_window(1'b0);
    drain_results();

    repeat (10) begin
        @(posedge clk);
        #1;
    end
    if (exp_q.size() == 0) begin
        $display("Result: PASSED");
        $finish;
    end else begin
        $display("%0d expected outputs left at the end of the run", exp_q.size());
        $display("Result: FAILED");
        $fatal(1);
    end
end

endmodule

`default_nettype wire

/* verification/vng_sva.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vng_consts.svh"

module vng_sva (
    input   wire                    clk,
    input   wire                    clk_en,
    input   wire                    reset,
    input   wire                    px_push,
    input   wire vng_pkg::pos_t     pos,
    input   wire                    load_grad,
    input   wire                    load_sum,
    input   wire                    load_out,
    input   wire                    out_valid
);

localparam vng_pkg::pos_t POS_LAST = vng_pkg::pos_t'(`VNG_WIN - 1);

logic   [`VNG_LAT-1:0]  ninth_hist;     // Ninth pushes, shifted once per enabled cycle
logic                   prev_valid;

always_ff @(posedge clk) begin
    if (reset) begin
        ninth_hist <= '0;
        prev_valid <= 1'b0;
    end else if (clk_en) begin
        ninth_hist <= {ninth_hist[`VNG_LAT-2:0], px_push && (pos == POS_LAST)};
        prev_valid <= out_valid;
    end
end

quiet_in_reset: assert property (@(posedge clk)
    reset |=> !(out_valid || load_grad || load_sum || load_out))
    else $error("valid or load pulse high during reset");

single_pulse: assert property (@(posedge clk) disable iff (reset)
    (clk_en && out_valid) |-> !prev_valid)
    else $error("out_valid high on two enabled cycles in a row");

// Both directions: no early, late or missing pulse
fixed_latency: assert property (@(posedge clk) disable iff (reset)
    clk_en |-> (out_valid == ninth_hist[`VNG_LAT-1]))
    else $error("out_valid not at the fixed latency after the ninth push");

pos_in_range: assert property (@(posedge clk) disable iff (reset)
    pos <= POS_LAST)
    else $error("window position out of range");

endmodule

bind vng_top vng_sva vng_sva_inst (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .reset      ( reset ),
    .px_push    ( px_push ),
    .pos        ( pos ),
    .load_grad  ( load_grad ),
    .load_sum   ( load_sum ),
    .load_out   ( load_out ),
    .out_valid  ( out_valid )
);

`default_nettype wire

/* source/vng_top.sv */
`timescale 1ns/1ns
`default_nettype none

module vng_top (
    input   wire                    clk,
    input   wire                    clk_en,
    input   wire                    reset,

    input   wire                    px_push,
    input   wire vng_pkg::pixel_t   px_in,
    input   wire                    px_masked,

    output  vng_pkg::pixel_t        out_red,
    output  vng_pkg::pixel_t        out_green,
    output  vng_pkg::pixel_t        out_blue,
    output  logic                   out_valid
);

vng_pkg::pos_t      pos;
logic               load_grad;
logic               load_sum;
logic               load_out;

vng_pkg::pixel_t    win_nw, win_n, win_ne, win_w, win_c, win_e, win_sw, win_s, win_se;
logic               win_masked;

vng_pkg::dir_mask_t grad_mask;
vng_pkg::pixel_t    g_nw, g_n, g_ne, g_w, g_c, g_e, g_sw, g_s, g_se;
logic               g_masked;

vng_pkg::sum_t      sum_green, sum_blue, alt_green, alt_blue;
vng_pkg::cnt_t      axis_cnt, diag_cnt;
vng_pkg::pixel_t    s_center;
logic               s_masked;

vng_control vng_control_inst (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .reset      ( reset ),
    .px_push    ( px_push ),
    .pos        ( pos ),
    .load_grad  ( load_grad ),
    .load_sum   ( load_sum ),
    .load_out   ( load_out )
);

vng_window vng_window_inst (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .px_push    ( px_push ),
    .px_in      ( px_in ),
    .px_masked  ( px_masked ),
    .pos        ( pos ),
    .win_nw     ( win_nw ),
    .win_n      ( win_n ),
    .win_ne     ( win_ne ),
    .win_w      ( win_w ),
    .win_c      ( win_c ),
    .win_e      ( win_e ),
    .win_sw     ( win_sw ),
    .win_s      ( win_s ),
    .win_se     ( win_se ),
    .win_masked ( win_masked )
);

vng_grad vng_grad_inst (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .load_grad  ( load_grad ),
    .win_nw     ( win_nw ),
    .win_n      ( win_n ),
    .win_ne     ( win_ne ),
    .win_w      ( win_w ),
    .win_c      ( win_c ),
    .win_e      ( win_e ),
    .win_sw     ( win_sw ),
    .win_s      ( win_s ),
    .win_se     ( win_se ),
    .win_masked ( win_masked ),
    .grad_mask  ( grad_mask ),
    .thresh     ( ),
    .g_nw       ( g_nw ),
    .g_n        ( g_n ),
    .g_ne       ( g_ne ),
    .g_w        ( g_w ),
    .g_c        ( g_c ),
    .g_e        ( g_e ),
    .g_sw       ( g_sw ),
    .g_s        ( g_s ),
    .g_se       ( g_se ),
    .g_masked   ( g_masked )
);

vng_sum vng_sum_inst (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .load_sum   ( load_sum ),
    .grad_mask  ( grad_mask ),
    .g_nw       ( g_nw ),
    .g_n        ( g_n ),
    .g_ne       ( g_ne ),
    .g_w        ( g_w ),
    .g_c        ( g_c ),
    .g_e        ( g_e ),
    .g_sw       ( g_sw ),
    .g_s        ( g_s ),
    .g_se       ( g_se ),
    .g_masked   ( g_masked ),
    .sum_green  ( sum_green ),
    .sum_blue   ( sum_blue ),
    .alt_green  ( alt_green ),
    .alt_blue   ( alt_blue ),
    .axis_cnt   ( axis_cnt ),
    .diag_cnt   ( diag_cnt ),
    .s_center   ( s_center ),
    .s_masked   ( s_masked )
);

vng_out vng_out_inst (
    .clk        ( clk ),
    .clk_en     ( clk_en ),
    .reset      ( reset ),
    .load_out   ( load_out ),
    .sum_green  ( sum_green ),
    .sum_blue   ( sum_blue ),
    .alt_green  ( alt_green ),
    .alt_blue   ( alt_blue ),
    .axis_cnt   ( axis_cnt ),
    .diag_cnt   ( diag_cnt ),
    .s_center   ( s_center ),
    .s_masked   ( s_masked ),
    .out_red    ( out_red ),
    .out_green  ( out_green ),
    .out_blue   ( out_blue ),
    .out_valid  ( out_valid )
);

endmodule

`default_nettype wire

/* source/vng_out.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vng_consts.svh"

module vng_out (
    input   wire                    clk,
    input   wire                    clk_en,
    input   wire                    reset,
    input   wire                    load_out,

    input   wire vng_pkg::sum_t     sum_green,
    input   wire vng_pkg::sum_t     sum_blue,
    input   wire vng_pkg::sum_t     alt_green,
    input   wire vng_pkg::sum_t     alt_blue,
    input   wire vng_pkg::cnt_t     axis_cnt,
    input   wire vng_pkg::cnt_t     diag_cnt,
    input   wire vng_pkg::pixel_t   s_center,
    input   wire                    s_masked,

    output  vng_pkg::pixel_t        out_red,
    output  vng_pkg::pixel_t        out_green,
    output  vng_pkg::pixel_t        out_blue,
    output  logic                   out_valid
);

// Divide by twice the count, or average all four when none kept
function automatic vng_pkg::pixel_t norm(input vng_pkg::sum_t sum,
                                         input vng_pkg::sum_t alt,
                                         input vng_pkg::cnt_t cnt);
    case (cnt)
        2'd1:    return sum[`VNG_DATA:1];
        2'd2:    return sum[`VNG_DATA+1:2];
        default: return alt[`VNG_DATA+1:2];
    endcase
endfunction

vng_pkg::pixel_t    green_norm;
vng_pkg::pixel_t    blue_norm;

assign green_norm = norm(sum_green, alt_green, axis_cnt);
assign blue_norm  = norm(sum_blue,  alt_blue,  diag_cnt);

always_ff @(posedge clk) begin
    if (clk_en && load_out) begin
        out_red   <= s_center;
        out_green <= s_masked ? s_center : green_norm;  // Masked site passes raw
        out_blue  <= s_masked ? s_center : blue_norm;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        out_valid <= 1'b0;
    end else if (clk_en) begin
        out_valid <= load_out;
    end
end

endmodule

`default_nettype wire

/* source/vng_sum.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vng_consts.svh"

module vng_sum (
    input   wire                        clk,
    input   wire                        clk_en,
    input   wire                        load_sum,

    input   wire vng_pkg::dir_mask_t    grad_mask,
    input   wire vng_pkg::pixel_t       g_nw,
    input   wire vng_pkg::pixel_t       g_n,
    input   wire vng_pkg::pixel_t       g_ne,
    input   wire vng_pkg::pixel_t       g_w,
    input   wire vng_pkg::pixel_t       g_c,
    input   wire vng_pkg::pixel_t       g_e,
    input   wire vng_pkg::pixel_t       g_sw,
    input   wire vng_pkg::pixel_t       g_s,
    input   wire vng_pkg::pixel_t       g_se,
    input   wire                        g_masked,

    output  vng_pkg::sum_t              sum_green,
    output  vng_pkg::sum_t              sum_blue,
    output  vng_pkg::sum_t              alt_green,
    output  vng_pkg::sum_t              alt_blue,
    output  vng_pkg::cnt_t              axis_cnt,
    output  vng_pkg::cnt_t              diag_cnt,
    output  vng_pkg::pixel_t            s_center,
    output  logic                       s_masked
);

logic           keep_h;
logic           keep_v;
logic           keep_ne;
logic           keep_se;
logic   [`VNG_DATA:0] pair_h;
logic   [`VNG_DATA:0] pair_v;
logic   [`VNG_DATA:0] pair_ne;
logic   [`VNG_DATA:0] pair_se;
vng_pkg::sum_t  green_next;
vng_pkg::sum_t  blue_next;

assign {keep_h, keep_v, keep_ne, keep_se} = grad_mask;

// Opposite neighbors along each direction
assign pair_h  = {1'b0, g_w}  + {1'b0, g_e};
assign pair_v  = {1'b0, g_n}  + {1'b0, g_s};
assign pair_ne = {1'b0, g_ne} + {1'b0, g_sw};
assign pair_se = {1'b0, g_nw} + {1'b0, g_se};

assign green_next = (keep_h  ? {1'b0, pair_h}  : '0) + (keep_v  ? {1'b0, pair_v}  : '0);
assign blue_next  = (keep_ne ? {1'b0, pair_ne} : '0) + (keep_se ? {1'b0, pair_se} : '0);

always_ff @(posedge clk) begin
    if (clk_en && load_sum) begin
        sum_green <= green_next;
        sum_blue  <= blue_next;
        alt_green <= {1'b0, pair_h}  + {1'b0, pair_v};    // Fallback, all four greens
        alt_blue  <= {1'b0, pair_ne} + {1'b0, pair_se};
        axis_cnt  <= {1'b0, keep_h}  + {1'b0, keep_v};
        diag_cnt  <= {1'b0, keep_ne} + {1'b0, keep_se};
        s_center  <= g_c;
        s_masked  <= g_masked;
    end
end

endmodule

`default_nettype wire

/* source/vng_grad.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vng_consts.svh"

module vng_grad (
    input   wire                    clk,
    input   wire                    clk_en,
    input   wire                    load_grad,

    input   wire vng_pkg::pixel_t   win_nw,
    input   wire vng_pkg::pixel_t   win_n,
    input   wire vng_pkg::pixel_t   win_ne,
    input   wire vng_pkg::pixel_t   win_w,
    input   wire vng_pkg::pixel_t   win_c,
    input   wire vng_pkg::pixel_t   win_e,
    input   wire vng_pkg::pixel_t   win_sw,
    input   wire vng_pkg::pixel_t   win_s,
    input   wire vng_pkg::pixel_t   win_se,
    input   wire                    win_masked,

    output  vng_pkg::dir_mask_t     grad_mask,
    output  vng_pkg::thresh_t       thresh,
    output  vng_pkg::pixel_t        g_nw,
    output  vng_pkg::pixel_t        g_n,
    output  vng_pkg::pixel_t        g_ne,
    output  vng_pkg::pixel_t        g_w,
    output  vng_pkg::pixel_t        g_c,
    output  vng_pkg::pixel_t        g_e,
    output  vng_pkg::pixel_t        g_sw,
    output  vng_pkg::pixel_t        g_s,
    output  vng_pkg::pixel_t        g_se,
    output  logic                   g_masked
);

function automatic vng_pkg::grad_t abs_diff(input vng_pkg::pixel_t a, input vng_pkg::pixel_t b);
    return (a > b) ? (a - b) : (b - a);
endfunction

vng_pkg::grad_t     grad_h;
vng_pkg::grad_t     grad_v;
vng_pkg::grad_t     grad_ne;
vng_pkg::grad_t     grad_se;
vng_pkg::grad_t     min_axis;
vng_pkg::grad_t     min_diag;
vng_pkg::grad_t     max_axis;
vng_pkg::grad_t     max_diag;
vng_pkg::grad_t     grad_min;
vng_pkg::grad_t     grad_max;
vng_pkg::grad_t     grad_span;
vng_pkg::thresh_t   thresh_next;
vng_pkg::dir_mask_t mask_next;

assign grad_h   = abs_diff(win_w,  win_e);
assign grad_v   = abs_diff(win_n,  win_s);
assign grad_ne  = abs_diff(win_ne, win_sw);
assign grad_se  = abs_diff(win_nw, win_se);

// Min and max as a two-level tree
assign min_axis = (grad_h  < grad_v)  ? grad_h  : grad_v;
assign min_diag = (grad_ne < grad_se) ? grad_ne : grad_se;
assign max_axis = (grad_h  > grad_v)  ? grad_h  : grad_v;
assign max_diag = (grad_ne > grad_se) ? grad_ne : grad_se;
assign grad_min = (min_axis < min_diag) ? min_axis : min_diag;
assign grad_max = (max_axis > max_diag) ? max_axis : max_diag;

// min + (max - min) / 2, never above max so no carry
assign grad_span   = grad_max - grad_min;
assign thresh_next = grad_min + {1'b0, grad_span[`VNG_DATA-1:1]};

// Minimum gradient always passes
assign mask_next = {grad_h  <= thresh_next,
                    grad_v  <= thresh_next,
                    grad_ne <= thresh_next,
                    grad_se <= thresh_next};

always_ff @(posedge clk) begin
    if (clk_en && load_grad) begin
        grad_mask <= mask_next;
        thresh    <= thresh_next;
        g_nw      <= win_nw;    // Window snapshot, frees the capture register
        g_n       <= win_n;
        g_ne      <= win_ne;
        g_w       <= win_w;
        g_c       <= win_c;
        g_e       <= win_e;
        g_sw      <= win_sw;
        g_s       <= win_s;
        g_se      <= win_se;
        g_masked  <= win_masked;
    end
end

endmodule

`default_nettype wire

/* source/vng_window.sv */
`timescale 1ns/1ns
`default_nettype none

module vng_window (
    input   wire                    clk,
    input   wire                    clk_en,

    input   wire                    px_push,
    input   wire vng_pkg::pixel_t   px_in,
    input   wire                    px_masked,
    input   wire vng_pkg::pos_t     pos,

    output  vng_pkg::pixel_t        win_nw,
    output  vng_pkg::pixel_t        win_n,
    output  vng_pkg::pixel_t        win_ne,
    output  vng_pkg::pixel_t        win_w,
    output  vng_pkg::pixel_t        win_c,
    output  vng_pkg::pixel_t        win_e,
    output  vng_pkg::pixel_t        win_sw,
    output  vng_pkg::pixel_t        win_s,
    output  vng_pkg::pixel_t        win_se,
    output  logic                   win_masked
);

// Raster order slots
always_ff @(posedge clk) begin
    if (clk_en && px_push) begin
        case (pos)
            4'd0:    win_nw <= px_in;
            4'd1:    win_n  <= px_in;
            4'd2:    win_ne <= px_in;
            4'd3:    win_w  <= px_in;
            4'd4:    win_c  <= px_in;
            4'd5:    win_e  <= px_in;
            4'd6:    win_sw <= px_in;
            4'd7:    win_s  <= px_in;
            4'd8:    win_se <= px_in;
            default: ;
        endcase
    end
end

// Mask flag belongs to the center site
always_ff @(posedge clk) begin
    if (clk_en && px_push && (pos == 4'd4)) begin
        win_masked <= px_masked;
    end
end

endmodule

`default_nettype wire

/* source/vng_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vng_consts.svh"

module vng_control (
    input   wire                clk,
    input   wire                clk_en,
    input   wire                reset,

    input   wire                px_push,

    output  vng_pkg::pos_t      pos,
    output  logic               load_grad,
    output  logic               load_sum,
    output  logic               load_out
);

localparam vng_pkg::pos_t POS_LAST = vng_pkg::pos_t'(`VNG_WIN - 1);

logic                   win_done;
logic   [`VNG_LAT-2:0]  load_pipe;  // One bit per stage after the window

// Ninth push closes the window
assign win_done = px_push && (pos == POS_LAST);

always_ff @(posedge clk) begin
    if (reset) begin
        pos <= '0;
    end else if (clk_en && px_push) begin
        if (pos == POS_LAST) begin
            pos <= '0;
        end else begin
            pos <= pos + 4'd1;
        end
    end
end

// Load chain, one enabled cycle per stage
always_ff @(posedge clk) begin
    if (reset) begin
        load_pipe <= '0;
    end else if (clk_en) begin
        load_pipe <= {load_pipe[`VNG_LAT-3:0], win_done};
    end
end

assign load_grad = load_pipe[0];
assign load_sum  = load_pipe[1];
assign load_out  = load_pipe[`VNG_LAT-2];

endmodule

`default_nettype wire

/* source/vng_pkg.sv */
`default_nettype none

`include "vng_consts.svh"

package vng_pkg;

    // Raw or output pixel
    typedef logic [`VNG_DATA-1:0] pixel_t;

    // Absolute difference of two pixels
    typedef logic [`VNG_DATA-1:0] grad_t;

    typedef logic [`VNG_DATA-1:0] thresh_t;

    // Kept directions, {h, v, ne, se} from MSB down
    typedef logic [3:0] dir_mask_t;

    // Up to four pixels added together
    typedef logic [`VNG_DATA+1:0] sum_t;

    // Kept directions in one class, 0 to 2
    typedef logic [1:0] cnt_t;

    typedef logic [3:0] pos_t;

endpackage

`default_nettype wire

/* include/vng_consts.svh */
`ifndef VNG_CONSTS_SVH
`define VNG_CONSTS_SVH

// Pixel width in bits
`define VNG_DATA 8

// Pixels per 3x3 window
`define VNG_WIN 9

// Enabled cycles from ninth push to out_valid
`define VNG_LAT 4

`endif
